/* flist.f */
+incdir+source
source/iob_wb_pkg.sv
source/iob_iob2wishbone.sv
source/iob_wb_ram.sv
source/iob_wb_subsys.sv
test/iob_wb_clk_gen.sv
test/iob_wb_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the IOb to Wishbone subsystem testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module iob_wb_tb \
   -f flist.f \
   --Mdir obj_dir \
   -o sim_iob_wb

# The simulator exits nonzero on a failure, so the log decides the result.
./obj_dir/sim_iob_wb 2>&1 | tee sim.log

if grep -q "^ALL TESTS PASSED$" sim.log; then
   echo "simulation passed, see sim.log"
   exit 0
else
   echo "simulation failed, see sim.log"
   exit 1
fi

/* test/iob_wb_tb.sv */
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_wb_tb;

   localparam int ADDR_W     = `IOB_WB_ADDR_W;
   localparam int DATA_W     = `IOB_WB_DATA_W;
   localparam int STRB_W     = DATA_W / 8;
   localparam int READ_BYTES = `IOB_WB_READ_BYTES;
   localparam int WAIT       = `IOB_WB_WAIT;
   localparam int MEM_WORDS  = `IOB_WB_MEM_WORDS;
   localparam int TEST_WORDS = 16;   // random traffic stays inside the words written first.
   localparam int RANDOM_OPS = 200;
   localparam int TIMEOUT    = 50;

   logic                 clk_i;
   logic                 rst_n_i;
   iob_wb_pkg::iob_req_t iob_req;
   iob_wb_pkg::iob_rsp_t iob_rsp;

   int         seed;
   logic [7:0] ref_bytes [MEM_WORDS*STRB_W];  // reference copy of the RAM, one entry per byte.

   iob_wb_clk_gen #(.PERIOD_NS(20.0)) u_clk_gen (.clk_o(clk_i));

   iob_wb_subsys DUT (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .iob_req_i(iob_req),
      .iob_rsp_o(iob_rsp)
   );

   task automatic stop_on_failure();
      $display("SOME TESTS FAILED");
      $fatal(1, "simulation stopped at the first failure.");
   endtask

   task automatic report_mismatch(input string test, input logic [DATA_W-1:0] exp,
                                  input logic [DATA_W-1:0] act);
      $display("[ERROR] %s: expected 0x%08h, actual 0x%08h", test, exp, act);
      stop_on_failure();
   endtask

   task automatic report_violation(input string what);
      $display("protocol check failed at %0t ns: %s.", $time, what);
      stop_on_failure();
   endtask

   task automatic report_timeout(input string what);
      $display("timeout: %s did not arrive within %0d cycles.", what, TIMEOUT);
      stop_on_failure();
   endtask

   // a read enables READ_BYTES lanes starting at the byte offset, cut at the word edge.
   function automatic logic [STRB_W-1:0] read_lane_mask(input logic [1:0] off);
      logic [STRB_W-1:0] mask;
      mask = '0;
      for (int i = 0; i < STRB_W; i++) begin
         mask[i] = (i >= int'(off)) && (i < int'(off) + READ_BYTES);
      end
      return mask;
   endfunction

   function automatic logic [DATA_W-1:0] expected_read(input int word, input logic [1:0] off);
      logic [STRB_W-1:0] mask;
      logic [DATA_W-1:0] value;
      mask  = read_lane_mask(off);
      value = '0;
      for (int i = 0; i < STRB_W; i++) begin
         if (mask[i]) value[8*i +: 8] = ref_bytes[word*STRB_W + i];
      end
      return value;
   endfunction

   function automatic logic [ADDR_W-1:0] make_addr(input int word, input logic [1:0] off);
      return (ADDR_W'(word) << 2) | ADDR_W'(off);
   endfunction

   // returns at a falling edge where ready is high, which is cycle 0 of the next request.
   task automatic wait_ready();
      int n;
      n = 0;
      while (iob_rsp.ready !== 1'b1) begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) report_timeout("ready");
      end
   endtask

   task automatic start_request(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                                input logic [STRB_W-1:0] wstrb);
      wait_ready();
      iob_req.avalid   = 1'b1;
      iob_req.addr.raw = addr;
      iob_req.wdata    = wdata;
      iob_req.wstrb    = wstrb;
      @(negedge clk_i);
      iob_req.avalid = 1'b0;  // one cycle pulse.
   endtask

   task automatic write_word(input int word, input logic [1:0] off,
                             input logic [DATA_W-1:0] data, input logic [STRB_W-1:0] strb);
      for (int i = 0; i < STRB_W; i++) begin
         if (strb[i]) ref_bytes[word*STRB_W + i] = data[8*i +: 8];
      end
      start_request(make_addr(word, off), data, strb);
   endtask

   task automatic read_check(input string test, input int word, input logic [1:0] off);
      logic [DATA_W-1:0] exp;
      int                n;
      exp = expected_read(word, off);
      start_request(make_addr(word, off), DATA_W'($random(seed)), '0);
      n = 0;
      while (iob_rsp.rvalid !== 1'b1) begin
         @(negedge clk_i);
         n++;
         if (n > TIMEOUT) report_timeout("rvalid after a read");
      end
      assert (iob_rsp.rdata === exp) else report_mismatch(test, exp, iob_rsp.rdata);
   endtask

   // rvalid comes exactly WAIT+1 cycles after a read and never after a write.
   a_rvalid_timing : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      iob_rsp.rvalid == $past(iob_req.avalid && (iob_req.wstrb == '0), WAIT + 1)
   ) else report_violation("rvalid does not match a read issued WAIT+1 cycles earlier");

   for (genvar k = 1; k <= WAIT; k++) begin : g_busy
      a_ready_low : assert property (
         @(posedge clk_i) disable iff (!rst_n_i)
         $past(iob_req.avalid, k) |-> !iob_rsp.ready
      ) else report_violation("ready is high while a request is still in flight");
   end

   a_ready_back : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      $past(iob_req.avalid, WAIT + 1) |-> iob_rsp.ready
   ) else report_violation("ready did not return WAIT+1 cycles after a request");

   initial begin
      int               word;
      int               is_write;
      logic [1:0]       off;
      logic [STRB_W-1:0] strb;
      seed        = 32'h66e8_6017;
      rst_n_i     = 1'b0;
      iob_req     = '0;
      repeat (10) @(negedge clk_i);
      rst_n_i = 1'b1;

      for (int i = 0; i < 5; i++) begin
         assert (iob_rsp.ready === 1'b1)
            else report_mismatch("reset_idle ready", 1, DATA_W'(iob_rsp.ready));
         assert (iob_rsp.rvalid === 1'b0)
            else report_mismatch("reset_idle rvalid", 0, DATA_W'(iob_rsp.rvalid));
         @(negedge clk_i);
      end

      // fills the test region so that every later read has known data.
      for (int w = 0; w < TEST_WORDS; w++) begin
         write_word(w, 2'd0, DATA_W'($random(seed)), {STRB_W{1'b1}});
      end
      for (int w = 0; w < TEST_WORDS; w++) begin
         read_check("full_word", w, 2'd0);
      end

      for (int s = 1; s < (1 << STRB_W) - 1; s++) begin
         write_word(5, 2'd0, DATA_W'($random(seed)), STRB_W'(s));
         read_check("partial_wstrb", 5, 2'd0);
      end

      for (int w = 0; w < 4; w++) begin
         for (int o = 1; o < 4; o++) begin
            read_check("offset_read", w, 2'(o));
         end
      end

      for (int n = 0; n < RANDOM_OPS; n++) begin
         word     = $random(seed) & (TEST_WORDS - 1);
         off      = 2'($random(seed));
         is_write = $random(seed) & 1;
         strb     = STRB_W'($random(seed));
         if (is_write != 0) begin
            if (strb == '0) strb = {STRB_W{1'b1}};  // an empty strobe would be a read.
            write_word(word, off, DATA_W'($random(seed)), strb);
         end else begin
            read_check("random", word, off);
         end
      end

      wait_ready();
      repeat (WAIT + 2) @(negedge clk_i);  // lets the timing checks see the last request.

      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* test/iob_wb_clk_gen.sv */
`timescale 1ns/1ps

module iob_wb_clk_gen #(
   parameter real PERIOD_NS = 20.0
) (
   output logic clk_o
);

   // free running, starts low so the first rising edge is at half a period.
   initial begin
      clk_o = 1'b0;
      forever begin
         #(PERIOD_NS / 2.0);
         clk_o = ~clk_o;
      end
   end

endmodule

/* source/iob_wb_subsys.sv */
`timescale 1ns/1ps

module iob_wb_subsys (
   input  logic                 clk_i,
   input  logic                 rst_n_i,

   input  iob_wb_pkg::iob_req_t iob_req_i,
   output iob_wb_pkg::iob_rsp_t iob_rsp_o
);

   iob_wb_pkg::wb_m2s_t wb_m2s;  // bridge to RAM.
   iob_wb_pkg::wb_s2m_t wb_s2m;  // RAM back to bridge.

   iob_iob2wishbone u_bridge (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .iob_req_i(iob_req_i),
      .iob_rsp_o(iob_rsp_o),
      .wb_o     (wb_m2s),
      .wb_i     (wb_s2m)
   );

   // single slave, so no address decode is needed.
   iob_wb_ram u_ram (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .wb_i   (wb_m2s),
      .wb_o   (wb_s2m)
   );

endmodule

/* source/iob_wb_ram.sv */
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_wb_ram (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  iob_wb_pkg::wb_m2s_t wb_i,
   output iob_wb_pkg::wb_s2m_t wb_o
);

   localparam int WAIT   = `IOB_WB_WAIT;
   localparam int CNT_W  = (WAIT > 0) ? $clog2(WAIT + 1) : 1;
   localparam int IDX_W  = $clog2(`IOB_WB_MEM_WORDS);
   localparam int STRB_W = `IOB_WB_DATA_W / 8;

   logic [`IOB_WB_DATA_W-1:0] mem [`IOB_WB_MEM_WORDS];

   logic [CNT_W-1:0]          wait_cnt;
   logic [IDX_W-1:0]          idx;
   logic [`IOB_WB_DATA_W-1:0] rd_word;
   logic                      ack;

   // address bits above the RAM depth are ignored.
   assign idx = wb_i.adr.fields.word_idx[IDX_W-1:0];

   // counts the stb cycles already waited. ack comes once WAIT have passed.
   assign ack = wb_i.stb & (wait_cnt == CNT_W'(WAIT));

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wait_cnt <= '0;
      end else if (!wb_i.stb || ack) begin
         wait_cnt <= '0;  // a following request starts a fresh count.
      end else begin
         wait_cnt <= wait_cnt + 1'b1;
      end
   end

   // byte writes happen on the acking edge.
   always_ff @(posedge clk_i) begin
      if (ack && wb_i.we) begin
         for (int i = 0; i < STRB_W; i++) begin
            if (wb_i.sel[i]) begin
               mem[idx][8*i +: 8] <= wb_i.dat[8*i +: 8];
            end
         end
      end
   end

   // Lanes outside sel read back as zero.
   always_comb begin
      rd_word = mem[idx];
      for (int i = 0; i < STRB_W; i++) begin
         if (!wb_i.sel[i]) begin
            rd_word[8*i +: 8] = 8'h00;
         end
      end
   end

   assign wb_o.ack = ack;
   assign wb_o.dat = rd_word;

   a_ack_in_cycle : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wb_o.ack |-> (wb_i.cyc && wb_i.stb)
   ) else $error("ack outside a bus cycle.");

   a_ack_single : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      wb_o.ack |=> !wb_o.ack
   ) else $error("ack high two cycles in a row.");

endmodule

/* source/iob_iob2wishbone.sv */
`timescale 1ns/1ps

`include "iob_wb_macros.svh"

module iob_iob2wishbone (
   input  logic                clk_i,
   input  logic                rst_n_i,

   input  iob_wb_pkg::iob_req_t iob_req_i,
   output iob_wb_pkg::iob_rsp_t iob_rsp_o,

   output iob_wb_pkg::wb_m2s_t  wb_o,
   input  iob_wb_pkg::wb_s2m_t  wb_i
);

   localparam int STRB_W = `IOB_WB_DATA_W / 8;

   // lanes a read asks for when the address is word aligned.
   localparam logic [STRB_W-1:0] RB_MASK = STRB_W'((1 << `IOB_WB_READ_BYTES) - 1);

   iob_wb_pkg::wb_m2s_t wb_req;   // the request as it arrives from IOb.
   iob_wb_pkg::wb_m2s_t hold_q;   // the request as it is held after cycle 0.

   logic                      avalid_q;
   logic                      stb;
   logic                      req_we;
   logic                      ack_q;
   logic [`IOB_WB_DATA_W-1:0] rdata_q;

   assign req_we = |iob_req_i.wstrb;

   // translate the incoming IOb request into a Wishbone cycle.
   always_comb begin
      wb_req.adr = iob_req_i.addr;
      wb_req.dat = iob_req_i.wdata;
      wb_req.we  = req_we;
      if (req_we) begin
         wb_req.sel = iob_req_i.wstrb;
      end else begin
         wb_req.sel = RB_MASK << iob_req_i.addr.fields.byte_off;  // upper lanes fall off.
      end
      wb_req.stb = iob_req_i.avalid;
      wb_req.cyc = iob_req_i.avalid;
   end

   // held valid. ack ends the cycle even if it lands in cycle 0.
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         avalid_q <= 1'b0;
      end else if (wb_i.ack) begin
         avalid_q <= 1'b0;
      end else if (iob_req_i.avalid) begin
         avalid_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (iob_req_i.avalid) begin
         hold_q <= wb_req;
      end
   end

   assign stb = iob_req_i.avalid | avalid_q;

   // the new request goes out directly, later cycles come from the hold register.
   always_comb begin
      if (iob_req_i.avalid) begin
         wb_o = wb_req;
      end else begin
         wb_o = hold_q;
      end
      wb_o.stb = stb;
      wb_o.cyc = stb;  // classic bus, cyc follows stb.
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= wb_i.ack;
      end
   end

   always_ff @(posedge clk_i) begin
      rdata_q <= wb_i.dat;
   end

   // hold_q.we still belongs to the acked request in the cycle after ack.
   assign iob_rsp_o.rvalid = ack_q & ~hold_q.we;
   assign iob_rsp_o.rdata  = rdata_q;
   assign iob_rsp_o.ready  = ~avalid_q | ack_q;

   // the master only starts a request when the bridge is free.
   a_no_req_when_busy : assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      iob_req_i.avalid |-> iob_rsp_o.ready
   ) else $error("avalid while ready is low.");

endmodule

/* source/iob_wb_pkg.sv */
`include "iob_wb_macros.svh"

package iob_wb_pkg;

   // a byte address split into the word index and the lane of its first byte.
   typedef struct packed {
      logic [`IOB_WB_ADDR_W-3:0] word_idx;
      logic [1:0]                byte_off;
   } iob_addr_fields_t;

   // the bridge looks at byte_off, the RAM at word_idx.
   typedef union packed {
      logic [`IOB_WB_ADDR_W-1:0] raw;
      iob_addr_fields_t          fields;
   } iob_addr_u;

   // request from the IOb master.
   typedef struct packed {
      logic                        avalid;
      iob_addr_u                   addr;
      logic [`IOB_WB_DATA_W-1:0]   wdata;
      logic [`IOB_WB_DATA_W/8-1:0] wstrb;  // all zero means a read.
   } iob_req_t;

   // response back to the IOb master.
   typedef struct packed {
      logic                      rvalid;
      logic [`IOB_WB_DATA_W-1:0] rdata;
      logic                      ready;
   } iob_rsp_t;

   // Wishbone classic, master to slave.
   typedef struct packed {
      iob_addr_u                   adr;
      logic [`IOB_WB_DATA_W/8-1:0] sel;
      logic                        we;
      logic                        cyc;
      logic                        stb;
      logic [`IOB_WB_DATA_W-1:0]   dat;
   } wb_m2s_t;

   // Wishbone classic, slave to master.
   typedef struct packed {
      logic                      ack;
      logic [`IOB_WB_DATA_W-1:0] dat;
   } wb_s2m_t;

endpackage

/* source/iob_wb_macros.svh */
`ifndef IOB_WB_MACROS_SVH
`define IOB_WB_MACROS_SVH

// byte address width of the IOb request and the Wishbone adr.
`define IOB_WB_ADDR_W 32

// data width on both buses, a whole number of bytes.
`define IOB_WB_DATA_W 32

// lanes fetched by a read before the shift by the byte offset.
`define IOB_WB_READ_BYTES 4

// RAM depth in data words.
`define IOB_WB_MEM_WORDS 256

// wait states the RAM inserts before its ack.
`define IOB_WB_WAIT 2

`endif
